/* vlog.f */
+incdir+.
fdiv_pkg.sv
fdiv_special.sv
fdiv_recurrence.sv
fdiv_normalize.sv
fdiv_top.sv
tb_fdiv.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_fdiv with verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --top-module tb_fdiv -f vlog.f -Mdir obj_dir -o tb_fdiv
	./obj_dir/tb_fdiv > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^TEST RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_fdiv.sv */
`default_nettype none

`include "fdiv_defines.svh"

module tb_fdiv;

	localparam int NUM_DIV = 40;
	localparam int NUM_SQRT = 40;
	localparam int NUM_UFL = 20;
	localparam int NUM_OPS = NUM_DIV + NUM_SQRT + NUM_UFL + 8 + 2; // busy case sends two.

	logic clock;
	logic reset;
	fdiv_pkg::fdiv_req_t req;
	fdiv_pkg::fdiv_result_t result;
	logic ready;
	logic [15:0] lfsr_state;
	int ready_pulses = 0;

	fdiv_top dut0 (
		.clock (clock),
		.reset (reset),
		.req_i (req),
		.result_o (result),
		.ready_o (ready)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		if (reset === 1'b1 && ready === 1'b1) ready_pulses <= ready_pulses + 1;
	end

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		repeat (n) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [127:0] int_sqrt(input logic [127:0] x);
		logic [127:0] root;
		logic [127:0] t;
		int i;
		root = '0;
		for (i = 63; i >= 0; i--) begin
			t = root | (128'h1 << i);
			if (t * t <= x) root = t;
		end
		return root;
	endfunction

	function automatic fdiv_pkg::fdiv_flags_t model_flags(input fdiv_pkg::fdiv_req_t r);
		fdiv_pkg::fdiv_flags_t f;
		logic [`FDIV_CLASS_W-1:0] c1;
		logic [`FDIV_CLASS_W-1:0] c2;
		logic a_zero, a_inf, a_nz, b_zero, b_inf, b_num;
		c1 = r.class1;
		c2 = r.fsqrt ? '0 : r.class2;
		a_zero = c1[3] | c1[4];
		a_inf = c1[0] | c1[7];
		a_nz = |{c1[6:5], c1[2:1]};
		b_zero = c2[3] | c2[4];
		b_inf = c2[0] | c2[7];
		b_num = |c2[6:1]; // any finite divisor.
		f.snan = c1[8] | c2[8] | (a_zero & b_zero) | (a_inf & b_inf);
		f.qnan = ~f.snan & (c1[9] | c2[9]);
		f.inf = a_inf & b_num;
		f.dbz = a_nz & b_zero;
		f.zero = a_zero | b_inf;
		if (r.fsqrt) begin
			f.inf = f.inf | c1[7];
			f.snan = f.snan | (|c1[2:0]);
		end
		return f;
	endfunction

	function automatic fdiv_pkg::fdiv_result_t model_result(input fdiv_pkg::fdiv_req_t r);
		fdiv_pkg::fdiv_result_t res;
		logic [127:0] sa;
		logic [127:0] sb;
		logic [127:0] q;
		logic [127:0] rem;
		logic [164:0] word;
		int drop;
		int e;
		sa = {75'h0, 1'b1, r.data1.frac};
		sb = {75'h0, 1'b1, r.data2.frac};
		drop = r.fmt ? 0 : 29; // single keeps quotient bits 54 down to 29.
		if (r.fsqrt) begin
			e = (int'(r.data1.exp) - 2045) >>> 1;
			if (!r.data1.exp[0]) sa = sa << 1;
			q = (int_sqrt(sa << 54) >> drop) << drop;
			rem = ((sa << 54) - q * q) >> drop;
		end else begin
			e = int'(r.data1.exp) - int'(r.data2.exp);
			q = (((sa << 54) / sb) >> drop) << drop;
			rem = ((sa << 55) - ((q * sb) << 1)) >> drop;
		end
		word = {q[54:0], rem[55:0], 54'h0};
		if (!word[164]) begin
			word = word << 1;
			e = e - 1;
		end
		e = e + (r.fmt ? 1023 : 127);
		res.exp = e[13:0];
		if (e <= 0) begin
			word = word >> ((1 - e > 54) ? 54 : 1 - e);
			res.exp = '0;
		end
		if (r.fmt) begin
			res.mant = {1'b0, word[164:112]};
			res.grs = {word[111], word[110], |word[109:0]};
		end else begin
			res.mant = {30'h0, word[164:141]};
			res.grs = {word[140], word[139], |word[138:0]};
		end
		res.sign = r.fsqrt ? r.data1.sign : r.data1.sign ^ r.data2.sign;
		res.fmt = r.fmt;
		res.rm = r.rm;
		res.flags = model_flags(r);
		return res;
	endfunction

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_result(input fdiv_pkg::fdiv_result_t got,
			input fdiv_pkg::fdiv_result_t want, input string what);
		if ({got.sign, got.exp, got.mant, got.grs, got.fmt, got.rm} !==
				{want.sign, want.exp, want.mant, want.grs, want.fmt, want.rm}) begin
			$display("** Error @ %0t: %s gave %b %h %h %b %b %h, expected %b %h %h %b %b %h",
				$time, what, got.sign, got.exp, got.mant, got.grs, got.fmt, got.rm,
				want.sign, want.exp, want.mant, want.grs, want.fmt, want.rm);
			abort_run();
		end
	endtask

	task automatic check_flags(input fdiv_pkg::fdiv_flags_t got,
			input fdiv_pkg::fdiv_flags_t want, input string what);
		if (got !== want) begin
			$display("** Error @ %0t: %s flags %b, expected %b", $time, what, got, want);
			abort_run();
		end
	endtask

	task automatic random_req(input logic sqrt_op, input logic fmt,
			output fdiv_pkg::fdiv_req_t r);
		logic [63:0] v;
		r = '0;
		r.fdiv = ~sqrt_op;
		r.fsqrt = sqrt_op;
		r.fmt = fmt;
		take_bits(62, v);
		r.data1 = {v[61] & ~sqrt_op, 12'd1536 + {3'h0, v[60:52]}, v[51:0]};
		take_bits(62, v);
		r.data2 = {v[61], 12'd1536 + {3'h0, v[60:52]}, v[51:0]};
		take_bits(3, v);
		r.rm = v[2:0];
		r.class1 = r.data1.sign ? 10'h002 : 10'h040; // normal operands.
		r.class2 = sqrt_op ? 10'h000 : (r.data2.sign ? 10'h002 : 10'h040);
	endtask

	task automatic send_request(input fdiv_pkg::fdiv_req_t r);
		@(posedge clock);
		req <= r;
		@(posedge clock);
		req.fdiv <= 1'b0;
		req.fsqrt <= 1'b0;
	endtask

	task automatic wait_ready();
		@(posedge clock);
		while (ready !== 1'b1) @(posedge clock);
	endtask

	task automatic run_op(input fdiv_pkg::fdiv_req_t r, input string what);
		fdiv_pkg::fdiv_result_t want;
		want = model_result(r);
		send_request(r);
		wait_ready();
		check_result(result, want, what);
		check_flags(result.flags, want.flags, what);
	endtask

	task automatic run_special(input logic sqrt_op, input logic [9:0] c1,
			input logic [9:0] c2, input string what);
		fdiv_pkg::fdiv_req_t r;
		random_req(sqrt_op, 1'b1, r);
		r.class1 = c1;
		r.class2 = c2;
		r.data1.sign = |c1[2:0];
		run_op(r, what);
	endtask

	initial begin
		#(NUM_OPS * 70 * 8);
		$display("timeout: the run did not finish within %0d cycles", NUM_OPS * 70);
		abort_run();
	end

	initial begin : main
		fdiv_pkg::fdiv_req_t r;
		fdiv_pkg::fdiv_result_t want;
		logic [63:0] v;
		int i;
		clock = 1'b0;
		reset <= 1'b0;
		req <= '0;
		lfsr_state = 16'd85;
		repeat (3) @(posedge clock);
		reset <= 1'b1;
		repeat (5) begin
			@(posedge clock);
			if (ready !== 1'b0) begin
				$display("ready_o went high with no request after reset");
				abort_run();
			end
		end
		for (i = 0; i < NUM_DIV; i++) begin
			random_req(1'b0, ~i[0], r);
			run_op(r, "divide");
		end
		for (i = 0; i < NUM_SQRT; i++) begin
			random_req(1'b1, i[0], r);
			run_op(r, "sqrt");
		end
		// divisor exponent large enough to push the result below the normal range.
		for (i = 0; i < NUM_UFL; i++) begin
			random_req(1'b0, i[0], r);
			take_bits(14, v);
			r.data1.exp = 12'd800 + {4'h0, v[7:0]};
			r.data2.exp = r.data1.exp + (r.fmt ? 12'd1023 : 12'd127) + {6'h0, v[13:8]};
			run_op(r, "underflow");
		end
		run_special(1'b0, 10'h010, 10'h008, "0/0");
		run_special(1'b0, 10'h080, 10'h001, "inf/inf");
		run_special(1'b0, 10'h040, 10'h010, "x/0");
		run_special(1'b0, 10'h100, 10'h040, "snan/x");
		run_special(1'b0, 10'h040, 10'h200, "x/qnan");
		run_special(1'b0, 10'h040, 10'h080, "x/inf");
		run_special(1'b1, 10'h002, 10'h000, "sqrt of negative");
		run_special(1'b1, 10'h080, 10'h000, "sqrt of +inf");
		random_req(1'b0, 1'b1, r);
		want = model_result(r);
		send_request(r);
		repeat (3) @(posedge clock);
		random_req(1'b1, 1'b0, r);
		send_request(r); // arrives while busy.
		wait_ready();
		check_result(result, want, "busy");
		check_flags(result.flags, want.flags, "busy");
		repeat (70) begin
			@(posedge clock);
			if (ready !== 1'b0) begin
				$display("a request sent while busy produced a second ready pulse");
				abort_run();
			end
		end
		if (ready_pulses != NUM_OPS - 1) begin
			$display("saw %0d ready pulses for %0d accepted requests", ready_pulses, NUM_OPS - 1);
			abort_run();
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* fdiv_top.sv */
`default_nettype none

module fdiv_top (
	input wire logic clock,
	input wire logic reset,
	input wire fdiv_pkg::fdiv_req_t req_i,
	output fdiv_pkg::fdiv_result_t result_o,
	output logic ready_o
);

	fdiv_pkg::fdiv_flags_t flags;
	fdiv_pkg::fdiv_iter_t iter;
	logic iter_done;

	// class decode, combinational.
	fdiv_special special0 (
		.req_i (req_i),
		.flags_o (flags)
	);

	fdiv_recurrence recurrence0 (
		.clock (clock),
		.reset (reset),
		.req_i (req_i),
		.flags_i (flags),
		.iter_o (iter),
		.iter_done_o (iter_done)
	);

	fdiv_normalize normalize0 (
		.clock (clock),
		.reset (reset),
		.iter_i (iter),
		.iter_done_i (iter_done),
		.result_o (result_o),
		.ready_o (ready_o)
	);

endmodule

`default_nettype wire

/* fdiv_normalize.sv */
`default_nettype none

`include "fdiv_defines.svh"

module fdiv_normalize (
	input wire logic clock,
	input wire logic reset,
	input wire fdiv_pkg::fdiv_iter_t iter_i,
	input wire logic iter_done_i,
	output fdiv_pkg::fdiv_result_t result_o,
	output logic ready_o
);

	logic [`FDIV_WORD_W-1:0] word_raw;
	logic [`FDIV_WORD_W-1:0] word_norm;
	logic lead_zero;
	logic [`FDIV_EXPR_W-1:0] bias;
	logic signed [`FDIV_EXPR_W-1:0] exp_biased;
	logic [`FDIV_EXPR_W-1:0] rshift_wide;
	logic [5:0] rshift;
	fdiv_pkg::fdiv_qword_u qword;
	fdiv_pkg::fdiv_result_t res_next;

	// quotient, remainder bits, then zero padding.
	assign word_raw = {iter_i.q, iter_i.rem[`FDIV_R_W-2:0], 54'h0};
	assign lead_zero = ~word_raw[`FDIV_WORD_W-1];
	assign word_norm = word_raw << lead_zero;

	assign bias = iter_i.fmt ? `FDIV_BIAS_D : `FDIV_BIAS_S;
	assign exp_biased = iter_i.exp + bias - {13'h0, lead_zero};
	assign rshift_wide = 14'sd1 - exp_biased;

	always_comb begin
		rshift = '0;
		res_next.exp = exp_biased;
		if (exp_biased <= 0) begin
			// subnormal result.
			rshift = `FDIV_SHIFT_MAX;
			if (exp_biased > -14'sd54) begin
				rshift = rshift_wide[5:0];
			end
			res_next.exp = '0;
		end
		qword = word_norm >> rshift;

		res_next.sign = iter_i.sign;
		res_next.fmt = iter_i.fmt;
		res_next.rm = iter_i.rm;
		res_next.flags = iter_i.flags;
		if (iter_i.fmt) begin
			res_next.mant = {1'b0, qword.dbl.mant};
			res_next.grs = {qword.dbl.guard, qword.dbl.round, |qword.dbl.sticky};
		end else begin
			res_next.mant = {30'h0, qword.sgl.mant};
			res_next.grs = {qword.sgl.guard, qword.sgl.round, |qword.sgl.sticky};
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			ready_o <= 1'b0;
		end else begin
			ready_o <= iter_done_i; // one cycle pulse.
		end
	end

	// result holds until the next operation completes.
	always_ff @(posedge clock) begin
		if (iter_done_i) begin
			result_o <= res_next;
		end
	end

endmodule

`default_nettype wire

/* fdiv_recurrence.sv */
`default_nettype none

`include "fdiv_defines.svh"

module fdiv_recurrence (
	input wire logic clock,
	input wire logic reset,
	input wire fdiv_pkg::fdiv_req_t req_i,
	input wire fdiv_pkg::fdiv_flags_t flags_i,
	output fdiv_pkg::fdiv_iter_t iter_o,
	output logic iter_done_o
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ITER = 2'd1;
	localparam logic [1:0] ST_DONE = 2'd2;
	localparam logic [1:0] ST_NORM = 2'd3;

	logic [1:0] state;
	logic [5:0] idx;
	logic [`FDIV_R_W-1:0] divisor;
	logic [`FDIV_R_W-1:0] trial;
	logic [`FDIV_R_W-1:0] shifted;
	logic [`FDIV_R_W-1:0] diff;
	logic [`FDIV_R_W-1:0] rem_init;
	logic signed [`FDIV_EXPR_W-1:0] exp_init;
	logic accept;
	logic last;
	fdiv_pkg::fdiv_operand_t a;
	fdiv_pkg::fdiv_operand_t b;

	assign a = req_i.data1;
	assign b = req_i.data2;
	assign accept = (state == ST_IDLE) & (req_i.fdiv | req_i.fsqrt);
	assign last = (idx == 6'd0) | (~iter_o.fmt & (idx == `FDIV_SINGLE_STOP));
	assign iter_done_o = (state == ST_DONE);

	always_comb begin
		exp_init = {2'b00, a.exp} - {2'b00, b.exp};
		rem_init = {5'h1, a.frac}; // implicit one.
		if (req_i.fsqrt) begin
			// drop the doubled bias and halve.
			exp_init = ($signed({2'b00, a.exp}) - 14'sd2045) >>> 1;
			if (!a.exp[0]) begin
				rem_init = {rem_init[`FDIV_R_W-2:0], 1'b0};
			end
		end
	end

	// sqrt tests the current root with the next bit set.
	always_comb begin
		trial = divisor;
		if (iter_o.sqrt) begin
			trial = {1'b0, iter_o.q, 1'b0};
			trial[idx] = 1'b1;
		end
	end

	assign shifted = {iter_o.rem[`FDIV_R_W-2:0], 1'b0};
	assign diff = shifted - trial;

	always_ff @(posedge clock) begin
		if (!reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) state <= ST_ITER;
				end
				ST_ITER: begin
					if (last) state <= ST_DONE;
				end
				ST_DONE: state <= ST_NORM;
				default: state <= ST_IDLE; // result leaves normalize here.
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			iter_o.q <= '0;
			iter_o.rem <= rem_init;
			iter_o.sign <= req_i.fsqrt ? a.sign : a.sign ^ b.sign;
			iter_o.exp <= exp_init;
			iter_o.sqrt <= req_i.fsqrt;
			iter_o.fmt <= req_i.fmt;
			iter_o.rm <= req_i.rm;
			iter_o.flags <= flags_i;
			divisor <= {4'h1, b.frac, 1'b0};
			idx <= req_i.fsqrt ? `FDIV_SQRT_START : `FDIV_DIV_START;
		end else if (state == ST_ITER) begin
			if (!diff[`FDIV_R_W-1]) begin
				iter_o.q[idx] <= 1'b1;
				iter_o.rem <= diff;
			end else begin
				iter_o.rem <= shifted;
			end
			if (!last) begin
				idx <= idx - 6'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* fdiv_special.sv */
`default_nettype none

`include "fdiv_defines.svh"

module fdiv_special (
	input wire fdiv_pkg::fdiv_req_t req_i,
	output fdiv_pkg::fdiv_flags_t flags_o
);

	logic [`FDIV_CLASS_W-1:0] ca;
	logic [`FDIV_CLASS_W-1:0] cb;
	logic a_zero, a_inf, a_fin;
	logic b_zero, b_inf, b_fin;

	assign ca = req_i.class1;
	assign cb = req_i.fsqrt ? '0 : req_i.class2; // sqrt has no divisor.

	assign a_zero = ca[3] | ca[4];
	assign a_inf = ca[0] | ca[7];
	assign a_fin = ca[1] | ca[2] | ca[5] | ca[6]; // finite and nonzero.
	assign b_zero = cb[3] | cb[4];
	assign b_inf = cb[0] | cb[7];
	assign b_fin = cb[1] | cb[2] | cb[5] | cb[6] | b_zero;

	always_comb begin
		flags_o = '0;
		if (ca[8] | cb[8]) begin
			flags_o.snan = 1'b1;
		end else if ((a_zero & b_zero) | (a_inf & b_inf)) begin
			flags_o.snan = 1'b1; // 0/0 and inf/inf are invalid.
		end else if (ca[9] | cb[9]) begin
			flags_o.qnan = 1'b1;
		end
		if (a_inf & b_fin) begin
			flags_o.inf = 1'b1;
		end else if (b_zero & a_fin) begin
			flags_o.dbz = 1'b1;
		end
		flags_o.zero = a_zero | b_inf;
		if (req_i.fsqrt) begin
			if (ca[7]) flags_o.inf = 1'b1;
			if (ca[0] | ca[1] | ca[2]) flags_o.snan = 1'b1; // negative root.
		end
	end

endmodule

`default_nettype wire

/* fdiv_pkg.sv */
`default_nettype none

`include "fdiv_defines.svh"

package fdiv_pkg;

	typedef struct packed {
		logic sign;
		logic [`FDIV_EXP_W-1:0] exp;
		logic [`FDIV_FRAC_W-1:0] frac;
	} fdiv_operand_t;

	typedef struct packed {
		logic snan; // also raised for invalid operations.
		logic qnan;
		logic dbz;
		logic inf;
		logic zero;
	} fdiv_flags_t;

	typedef struct packed {
		logic fdiv;
		logic fsqrt;
		fdiv_operand_t data1;
		fdiv_operand_t data2; // ignored for sqrt.
		logic [`FDIV_CLASS_W-1:0] class1;
		logic [`FDIV_CLASS_W-1:0] class2;
		logic fmt; // 0 single, 1 double.
		logic [2:0] rm;
	} fdiv_req_t;

	typedef struct packed {
		logic sign;
		logic [`FDIV_EXPR_W-1:0] exp;
		logic [`FDIV_MANT_W-1:0] mant;
		logic [2:0] grs;
		logic fmt;
		logic [2:0] rm;
		fdiv_flags_t flags;
	} fdiv_result_t;

	typedef struct packed {
		logic [`FDIV_Q_W-1:0] q;
		logic [`FDIV_R_W-1:0] rem;
		logic sign;
		logic signed [`FDIV_EXPR_W-1:0] exp;
		logic sqrt;
		logic fmt;
		logic [2:0] rm;
		fdiv_flags_t flags;
	} fdiv_iter_t;

	typedef struct packed {
		logic [23:0] mant;
		logic guard;
		logic round;
		logic [138:0] sticky;
	} fdiv_qsingle_t;

	typedef struct packed {
		logic [52:0] mant;
		logic guard;
		logic round;
		logic [109:0] sticky;
	} fdiv_qdouble_t;

	// normalized quotient word, split by format.
	typedef union packed {
		fdiv_qsingle_t sgl;
		fdiv_qdouble_t dbl;
	} fdiv_qword_u;

endpackage

`default_nettype wire

/* fdiv_defines.svh */
`ifndef FDIV_DEFINES_SVH
`define FDIV_DEFINES_SVH

// operand field widths.
`define FDIV_FRAC_W 52
`define FDIV_EXP_W 12
`define FDIV_CLASS_W 10

// working widths inside the unit.
`define FDIV_EXPR_W 14
`define FDIV_MANT_W 54
`define FDIV_Q_W 55
`define FDIV_R_W 57
`define FDIV_WORD_W 165

`define FDIV_BIAS_S 14'd127
`define FDIV_BIAS_D 14'd1023

// bit indices of the recurrence.
`define FDIV_DIV_START 6'd54
`define FDIV_SQRT_START 6'd53
`define FDIV_SINGLE_STOP 6'd29
`define FDIV_SHIFT_MAX 6'd54 // subnormal shift limit.

`endif
